// File: list.f
logic/cbr_pkg.sv
logic/cbr_cfg_regs.sv
logic/cbr_kernel_controller.sv
logic/cbr_lane_array.sv
logic/cbr_requant_pipe.sv
logic/cbr_out_fifo.sv
logic/cbr_core_top.sv
tests/cbr_tb.sv

// File: logic/cbr_cfg_regs.sv
module cbr_cfg_regs import cbr_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  // write address and data
  input  logic                  awvalid,
  output logic                  awready,
  input  axi_addr_t             awaddr,
  input  logic                  wvalid,
  output logic                  wready,
  input  axi_data_t             wdata,
  input  axi_strb_t             wstrb,
  output logic                  bvalid,
  input  logic                  bready,
  output axi_resp_t             bresp,
  // read
  input  logic                  arvalid,
  output logic                  arready,
  input  axi_addr_t             araddr,
  output logic                  rvalid,
  input  logic                  rready,
  output axi_data_t             rdata,
  output axi_resp_t             rresp,
  // configuration out
  output mode_t                 cfg_mode,
  output len_t                  cfg_len,
  output pof_t                  cfg_pof,
  output scale_t [ROWS-1:0]     cfg_scale,
  output bias_t  [ROWS-1:0]     cfg_bias
);

  mode_t mode_q;
  len_t len_q;
  pof_t pof_q;
  scale_t [ROWS-1:0] scale_q;
  bias_t [ROWS-1:0] bias_q;
  logic wr_fire;
  axi_data_t wr_old;
  axi_data_t wr_merged;
  axi_data_t rd_val;

  function automatic logic is_scale(axi_addr_t a);
    return (a >= ADDR_SCALE) && (a < ADDR_SCALE + 4 * ROWS) && (a[1:0] == 2'b00);
  endfunction

  function automatic logic is_bias(axi_addr_t a);
    return (a >= ADDR_BIAS) && (a < ADDR_BIAS + 4 * ROWS) && (a[1:0] == 2'b00);
  endfunction

  function automatic logic is_mapped(axi_addr_t a);
    return (a == ADDR_MODE) || (a == ADDR_LEN) || (a == ADDR_POF) || is_scale(a) || is_bias(a);
  endfunction

  // word view of a register, 0 when unmapped
  function automatic axi_data_t reg_value(axi_addr_t a);
    axi_data_t v;
    v = '0;
    if (a == ADDR_MODE) v = axi_data_t'(mode_q);
    else if (a == ADDR_LEN) v = axi_data_t'(len_q);
    else if (a == ADDR_POF) v = axi_data_t'(pof_q);
    else if (is_scale(a)) v = axi_data_t'(scale_q[row_t'((a - ADDR_SCALE) >> 2)]);
    // bias comes back zero extended
    else if (is_bias(a)) v = {16'h0000, bias_q[row_t'((a - ADDR_BIAS) >> 2)]};
    return v;
  endfunction

  function automatic pof_t sat_pof(axi_data_t v);
    if (v == 0) return pof_t'(1);
    if (v > ROWS) return pof_t'(ROWS);
    return pof_t'(v);
  endfunction

  ////////////////////////////////////////
  // write channel
  ////////////////////////////////////////
  // address and data taken together, one response outstanding
  assign awready = awvalid && wvalid && !bvalid;
  assign wready = awready;
  assign wr_fire = awready;

  always_comb begin
    wr_old = reg_value(awaddr);
    wr_merged = wr_old;
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) wr_merged[8*b +: 8] = wdata[8*b +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mode_q <= MODE_SHARED;
      len_q <= RST_LEN;
      pof_q <= RST_POF;
      scale_q <= {ROWS{RST_SCALE}};
      bias_q <= '0;
      bvalid <= 1'b0;
    end else begin
      if (bvalid && bready) bvalid <= 1'b0;
      if (wr_fire) begin
        bvalid <= 1'b1;
        bresp <= is_mapped(awaddr) ? RESP_OKAY : RESP_SLVERR;
        if (awaddr == ADDR_MODE) mode_q <= mode_t'(wr_merged);
        else if (awaddr == ADDR_LEN) len_q <= len_t'(wr_merged);
        else if (awaddr == ADDR_POF) pof_q <= sat_pof(wr_merged);
        else if (is_scale(awaddr))
          scale_q[row_t'((awaddr - ADDR_SCALE) >> 2)] <= scale_t'(wr_merged);
        else if (is_bias(awaddr))
          bias_q[row_t'((awaddr - ADDR_BIAS) >> 2)] <= bias_t'(wr_merged);
      end
    end
  end

  ////////////////////////////////////////
  // read channel
  ////////////////////////////////////////
  assign arready = !rvalid;

  always_comb begin
    rd_val = reg_value(araddr);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else begin
      if (rvalid && rready) rvalid <= 1'b0;
      if (arvalid && arready) rvalid <= 1'b1;
    end
  end

  // response payload, no reset
  always_ff @(posedge clk) begin
    if (arvalid && arready) begin
      rdata <= rd_val;
      rresp <= is_mapped(araddr) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assign cfg_mode = mode_q;
  assign cfg_len = len_q;
  assign cfg_pof = pof_q;
  assign cfg_scale = scale_q;
  assign cfg_bias = bias_q;

  // write response must wait for the master
  assert property (@(posedge clk) disable iff (reset) bvalid && !bready |=> bvalid);

endmodule

// File: logic/cbr_core_top.sv
module cbr_core_top import cbr_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  // axi4-lite
  input  logic              awvalid,
  output logic              awready,
  input  axi_addr_t         awaddr,
  input  logic              wvalid,
  output logic              wready,
  input  axi_data_t         wdata,
  input  axi_strb_t         wstrb,
  output logic              bvalid,
  input  logic              bready,
  output axi_resp_t         bresp,
  input  logic              arvalid,
  output logic              arready,
  input  axi_addr_t         araddr,
  output logic              rvalid,
  input  logic              rready,
  output axi_data_t         rdata,
  output axi_resp_t         rresp,
  // pixel stream in
  input  logic              px_valid,
  output logic              px_ready,
  input  act_t [ROWS-1:0]   px_act,
  input  wgt_t [ROWS-1:0]   px_wgt,
  // result stream out
  output logic              out_valid,
  input  logic              out_ready,
  output res_t              out_data,
  output row_t              out_row
);

  mode_t cfg_mode;
  len_t cfg_len;
  pof_t cfg_pof;
  scale_t [ROWS-1:0] cfg_scale;
  bias_t [ROWS-1:0] cfg_bias;
  logic fifo_room;
  logic accum_en;
  logic drain_en;
  row_t drain_row;
  row_t row_scale_sel;
  logic stage1_en;
  logic stage2_en;
  logic stage3_en;
  logic lane_clear;
  acc_t lane_sum;
  res_t res;
  row_t res_row;

  cbr_cfg_regs u_cfg_regs (
    .clk, .reset,
    .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
    .bvalid, .bready, .bresp,
    .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
    .cfg_mode, .cfg_len, .cfg_pof, .cfg_scale, .cfg_bias
  );

  cbr_kernel_controller u_ctrl (
    .clk, .reset, .cfg_mode, .cfg_len, .cfg_pof,
    .px_valid, .px_ready, .fifo_room,
    .accum_en, .drain_en, .drain_row, .row_scale_sel,
    .stage1_en, .stage2_en, .stage3_en, .lane_clear
  );

  cbr_lane_array u_lanes (
    .clk, .reset, .accum_en, .px_act, .px_wgt, .lane_clear, .drain_row, .lane_sum
  );

  cbr_requant_pipe u_requant (
    .clk, .reset, .drain_en, .drain_row, .row_scale_sel, .lane_sum,
    .cfg_scale, .cfg_bias, .stage1_en, .stage2_en, .stage3_en, .res, .res_row
  );

  // fifo write is the last stage enable
  cbr_out_fifo u_out_fifo (
    .clk, .reset,
    .wr_en(stage3_en), .wr_data(res), .wr_row(res_row),
    .out_valid, .out_ready, .out_data, .out_row, .fifo_room
  );

endmodule

// File: logic/cbr_kernel_controller.sv
module cbr_kernel_controller import cbr_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  mode_t cfg_mode,
  input  len_t  cfg_len,
  input  pof_t  cfg_pof,
  input  logic  px_valid,
  output logic  px_ready,
  input  logic  fifo_room,
  output logic  accum_en,
  output logic  drain_en,
  output row_t  drain_row,
  output row_t  row_scale_sel,
  output logic  stage1_en,
  output logic  stage2_en,
  output logic  stage3_en,
  output logic  lane_clear
);

  ctrl_state_t state_q;
  len_t pix_cnt;
  row_t drain_cnt;
  // tile config, latched on the first beat
  mode_t mode_q;
  len_t len_q;
  pof_t pof_q;
  logic tile_start;
  logic beat_ok;
  logic last_row;

  ////////////////////////////////////////
  // pixel phase
  ////////////////////////////////////////
  // first beat accepted in idle, only with room for a whole tile
  assign tile_start = (state_q == ST_IDLE) && px_valid && fifo_room;
  // beats 1 .. len-1, the extra accum cycle lets the last product land
  assign beat_ok = (state_q == ST_ACCUM) && (pix_cnt < len_q);
  assign px_ready = ((state_q == ST_IDLE) && fifo_room) || beat_ok;
  assign accum_en = tile_start || beat_ok;

  ////////////////////////////////////////
  // drain phase
  ////////////////////////////////////////
  assign last_row = (pof_t'(drain_cnt) == pof_q - pof_t'(1));
  assign drain_en = (state_q == ST_DRAIN);
  assign drain_row = drain_cnt;
  // mult array mode, each row picks its own scale
  assign row_scale_sel = (mode_q == MODE_PER_ROW) ? drain_cnt : '0;
  // sums are read this cycle, cleared at its end
  assign lane_clear = drain_en && last_row;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= ST_IDLE;
      pix_cnt <= '0;
      drain_cnt <= '0;
      mode_q <= MODE_SHARED;
      len_q <= RST_LEN;
      pof_q <= RST_POF;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (tile_start) begin
            mode_q <= cfg_mode;
            len_q <= (cfg_len == '0) ? len_t'(1) : cfg_len;
            pof_q <= cfg_pof;
            pix_cnt <= len_t'(1);
            state_q <= ST_ACCUM;
          end
        end
        ST_ACCUM: begin
          if (pix_cnt == len_q) begin
            // all sums final next cycle
            drain_cnt <= '0;
            state_q <= ST_DRAIN;
          end else begin
            pix_cnt <= pix_cnt + len_t'(1);
          end
        end
        ST_DRAIN: begin
          if (last_row) state_q <= ST_FLUSH;
          else drain_cnt <= drain_cnt + row_t'(1);
        end
        ST_FLUSH: begin
          state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // stage enables ride one cycle behind each other
  always_ff @(posedge clk) begin
    if (reset) begin
      stage1_en <= 1'b0;
      stage2_en <= 1'b0;
      stage3_en <= 1'b0;
    end else begin
      stage1_en <= drain_en;
      stage2_en <= stage1_en;
      stage3_en <= stage2_en;
    end
  end

  // the source may not pause inside a tile
  assert property (@(posedge clk) disable iff (reset) beat_ok |-> px_valid);
  assert property (@(posedge clk) disable iff (reset) drain_en |-> (pof_t'(drain_row) < pof_q));

endmodule

// File: logic/cbr_lane_array.sv
module cbr_lane_array import cbr_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              accum_en,
  input  act_t [ROWS-1:0]   px_act,
  input  wgt_t [ROWS-1:0]   px_wgt,
  input  logic              lane_clear,
  input  row_t              drain_row,
  output acc_t              lane_sum
);

  // int8 by int8 fits in 16 bits
  logic signed [15:0] prod_q [ROWS];
  logic prod_vld_q;
  acc_t acc_q [ROWS];

  ////////////////////////////////////////
  // product stage
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    for (int i = 0; i < ROWS; i++) begin
      prod_q[i] <= act_t'(px_act[i]) * wgt_t'(px_wgt[i]);
    end
  end

  // marks which registered products belong to the tile
  always_ff @(posedge clk) begin
    if (reset) prod_vld_q <= 1'b0;
    else prod_vld_q <= accum_en;
  end

  ////////////////////////////////////////
  // accumulators
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset || lane_clear) begin
      for (int i = 0; i < ROWS; i++) begin
        acc_q[i] <= '0;
      end
    end else if (prod_vld_q) begin
      for (int i = 0; i < ROWS; i++) begin
        // sign extend before the add
        acc_q[i] <= acc_q[i] + acc_t'(prod_q[i]);
      end
    end
  end

  // one row per drain cycle
  assign lane_sum = acc_q[drain_row];

endmodule

// File: logic/cbr_out_fifo.sv
module cbr_out_fifo import cbr_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic wr_en,
  input  res_t wr_data,
  input  row_t wr_row,
  output logic out_valid,
  input  logic out_ready,
  output res_t out_data,
  output row_t out_row,
  output logic fifo_room
);

  res_t data_mem [FIFO_DEPTH];
  row_t row_mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  fifo_cnt_t count;
  fifo_cnt_t free_cnt;
  logic rd_en;

  assign out_valid = (count != '0);
  assign rd_en = out_valid && out_ready;
  assign out_data = data_mem[rd_ptr];
  assign out_row = row_mem[rd_ptr];

  // room for a full tile after what the pipe may still deliver
  assign free_cnt = fifo_cnt_t'(FIFO_DEPTH) - count;
  assign fifo_room = (free_cnt >= ROWS + PIPE_LAG);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      data_mem[wr_ptr] <= wr_data;
      row_mem[wr_ptr] <= wr_row;
    end
  end

  // pointers wrap at depth, a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      if (wr_en && !rd_en) count <= count + 1'b1;
      else if (!wr_en && rd_en) count <= count - 1'b1;
    end
  end

  // controller must hold off a tile before the buffer can fill
  assert property (@(posedge clk) disable iff (reset) wr_en |-> (count != FIFO_DEPTH));

endmodule

// File: logic/cbr_pkg.sv
package cbr_pkg;

  ////////////////////////////////////////
  // core geometry
  ////////////////////////////////////////
  localparam int ROWS = 4;
  localparam int SHIFT = 8;
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  // results still in the requant pipe when the controller is back in idle
  localparam int PIPE_LAG = 2;
  localparam int RES_MAX = 127;

  ////////////////////////////////////////
  // data widths
  ////////////////////////////////////////
  typedef logic signed [7:0] act_t;
  typedef logic signed [7:0] wgt_t;
  typedef logic signed [31:0] acc_t;
  // 256 is 1.0
  typedef logic [15:0] scale_t;
  typedef logic signed [15:0] bias_t;
  typedef logic [7:0] res_t;
  typedef logic [1:0] row_t;
  // nif*k*k beats per tile
  typedef logic [15:0] len_t;
  typedef logic [2:0] pof_t;
  typedef logic [1:0] mode_t;
  typedef logic [FIFO_PTR_W:0] fifo_cnt_t;

  localparam mode_t MODE_SHARED = 2'd0;
  localparam mode_t MODE_PER_ROW = 2'd1;

  typedef enum logic [1:0] {ST_IDLE, ST_ACCUM, ST_DRAIN, ST_FLUSH} ctrl_state_t;

  ////////////////////////////////////////
  // axi4-lite register map
  ////////////////////////////////////////
  typedef logic [7:0] axi_addr_t;
  typedef logic [31:0] axi_data_t;
  typedef logic [3:0] axi_strb_t;
  typedef logic [1:0] axi_resp_t;

  localparam axi_resp_t RESP_OKAY = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;

  localparam axi_addr_t ADDR_MODE = 8'h00;
  localparam axi_addr_t ADDR_LEN = 8'h04;
  localparam axi_addr_t ADDR_POF = 8'h08;
  // tables, one word per row
  localparam axi_addr_t ADDR_SCALE = 8'h10;
  localparam axi_addr_t ADDR_BIAS = 8'h20;

  localparam len_t RST_LEN = 16'd9;
  localparam pof_t RST_POF = pof_t'(ROWS);
  localparam scale_t RST_SCALE = 16'd256;

endpackage

// File: logic/cbr_requant_pipe.sv
module cbr_requant_pipe import cbr_pkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic                drain_en,
  input  row_t                drain_row,
  input  row_t                row_scale_sel,
  input  acc_t                lane_sum,
  input  scale_t [ROWS-1:0]   cfg_scale,
  input  bias_t  [ROWS-1:0]   cfg_bias,
  input  logic                stage1_en,
  input  logic                stage2_en,
  input  logic                stage3_en,
  output res_t                res,
  output row_t                res_row
);

  // 32 x 17 bit product, shifted
  logic signed [48:0] scaled;
  logic signed [48:0] s1_q;
  logic signed [49:0] s2_q;
  res_t s3_q;
  row_t row1_q;
  row_t row2_q;
  row_t row3_q;

  ////////////////////////////////////////
  // stage 1: sum times E
  ////////////////////////////////////////
  // scale is unsigned, zero pad it before the signed multiply
  assign scaled = (lane_sum * $signed({1'b0, cfg_scale[row_scale_sel]})) >>> SHIFT;

  always_ff @(posedge clk) begin
    if (drain_en) begin
      s1_q <= scaled;
      row1_q <= drain_row;
    end
  end

  ////////////////////////////////////////
  // stage 2: add bias of the row
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (stage1_en) begin
      s2_q <= s1_q + cfg_bias[row1_q];
      row2_q <= row1_q;
    end
  end

  ////////////////////////////////////////
  // stage 3: relu, clamp to 0..127
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      s3_q <= '0;
      row3_q <= '0;
    end else if (stage2_en) begin
      if (s2_q < 0) s3_q <= '0;
      else if (s2_q > RES_MAX) s3_q <= res_t'(RES_MAX);
      else s3_q <= res_t'(s2_q);
      row3_q <= row2_q;
    end
  end

  // result only shown in its write cycle, zero otherwise
  assign res = stage3_en ? s3_q : '0;
  assign res_row = stage3_en ? row3_q : '0;

endmodule

// File: tests/cbr_tb.sv
module cbr_tb import cbr_pkg::*; ();

  logic clk;
  logic reset;
  logic awvalid;
  logic awready;
  axi_addr_t awaddr;
  logic wvalid;
  logic wready;
  axi_data_t wdata;
  axi_strb_t wstrb;
  logic bvalid;
  logic bready;
  axi_resp_t bresp;
  logic arvalid;
  logic arready;
  axi_addr_t araddr;
  logic rvalid;
  logic rready;
  axi_data_t rdata;
  axi_resp_t rresp;
  logic px_valid;
  logic px_ready;
  act_t [ROWS-1:0] px_act;
  wgt_t [ROWS-1:0] px_wgt;
  logic out_valid;
  logic out_ready;
  res_t out_data;
  row_t out_row;

  // shadow of the config registers
  mode_t mode_m;
  len_t len_m;
  pof_t pof_m;
  scale_t scale_m [ROWS];
  bias_t bias_m [ROWS];

  // results in drain order
  res_t exp_res_q [$];
  row_t exp_row_q [$];

  // cycle limit grows with every access and tile
  int budget = 100;
  int cycle_cnt = 0;

  cbr_core_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////
  // failure and compare helpers
  ////////////////////////////////////////
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_res(input string name, input res_t got, input res_t exp);
    if (got !== exp)
      fail_run($sformatf("error at %0t: %s = %0d, expected %0d", $time, name, got, exp));
  endtask

  task automatic check_row(input string name, input row_t got, input row_t exp);
    if (got !== exp)
      fail_run($sformatf("error at %0t: %s = %0d, expected %0d", $time, name, got, exp));
  endtask

  task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
    if (got !== exp)
      fail_run($sformatf("error at %0t: %s = %b, expected %b", $time, name, got, exp));
  endtask

  task automatic check_data(input string name, input axi_data_t got, input axi_data_t exp);
    if (got !== exp)
      fail_run($sformatf("error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp));
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > budget)
      fail_run($sformatf("run timed out after %0d cycles", cycle_cnt));
  end

  // relu of scaled sum plus bias, then clamp to 0..127
  function automatic res_t model_res(input longint sum, input scale_t sc, input bias_t bi);
    longint v;
    v = (sum * longint'(sc)) >>> SHIFT;
    v = v + longint'(bi);
    if (v < 0) return res_t'(0);
    if (v > 127) return res_t'(127);
    return res_t'(v);
  endfunction

  ////////////////////////////////////////
  // axi4-lite master
  ////////////////////////////////////////
  task automatic axi_write(input axi_addr_t addr, input axi_data_t data, output axi_resp_t resp);
    budget += 50;
    @(posedge clk);
    awvalid <= 1'b1;
    wvalid <= 1'b1;
    awaddr <= addr;
    wdata <= data;
    wstrb <= 4'hf;
    bready <= 1'b1;
    @(negedge clk);
    while (!(awready && wready)) @(negedge clk);
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    resp = bresp;
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic axi_read(input axi_addr_t addr, output axi_data_t data, output axi_resp_t resp);
    budget += 50;
    @(posedge clk);
    arvalid <= 1'b1;
    araddr <= addr;
    rready <= 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    arvalid <= 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    data = rdata;
    resp = rresp;
    @(posedge clk);
    rready <= 1'b0;
  endtask

  // write a mapped register and mirror it in the shadow
  task automatic write_cfg(input axi_addr_t addr, input axi_data_t data);
    axi_resp_t rs;
    axi_write(addr, data, rs);
    check_resp("bresp", rs, RESP_OKAY);
    if (addr == ADDR_MODE) mode_m = mode_t'(data);
    else if (addr == ADDR_LEN) len_m = len_t'(data);
    else if (addr == ADDR_POF)
      pof_m = (data == 0) ? pof_t'(1) : (data > ROWS) ? pof_t'(ROWS) : pof_t'(data);
    else if (addr >= ADDR_BIAS) bias_m[(addr - ADDR_BIAS) >> 2] = bias_t'(data);
    else scale_m[(addr - ADDR_SCALE) >> 2] = scale_t'(data);
  endtask

  task automatic read_check(input axi_addr_t addr, input axi_data_t exp);
    axi_data_t d;
    axi_resp_t rs;
    axi_read(addr, d, rs);
    check_resp("rresp", rs, RESP_OKAY);
    check_data("rdata", d, exp);
  endtask

  ////////////////////////////////////////
  // pixel and result streams
  ////////////////////////////////////////
  // one tile of the configured length, constant beats unless rnd
  // expectations pushed per drained row
  task automatic send_tile(input bit rnd,
                           input act_t [ROWS-1:0] act_c, input wgt_t [ROWS-1:0] wgt_c);
    longint sums [ROWS];
    act_t [ROWS-1:0] a;
    wgt_t [ROWS-1:0] w;
    scale_t sc;
    budget += len_m + 20;
    for (int r = 0; r < ROWS; r++) sums[r] = 0;
    for (int b = 0; b < len_m; b++) begin
      for (int r = 0; r < ROWS; r++) begin
        a[r] = rnd ? act_t'(int'($urandom_range(31, 0)) - 16) : act_c[r];
        w[r] = rnd ? wgt_t'(int'($urandom_range(31, 0)) - 16) : wgt_c[r];
        sums[r] += longint'(a[r]) * longint'(w[r]);
      end
      @(posedge clk);
      px_valid <= 1'b1;
      px_act <= a;
      px_wgt <= w;
      @(negedge clk);
      if (b == 0) begin
        // first beat waits for room in the fifo
        while (!px_ready) @(negedge clk);
      end else if (!px_ready) begin
        fail_run("px_ready dropped in the middle of a tile");
      end
    end
    @(posedge clk);
    px_valid <= 1'b0;
    for (int r = 0; r < pof_m; r++) begin
      sc = (mode_m == MODE_PER_ROW) ? scale_m[r] : scale_m[0];
      exp_res_q.push_back(model_res(sums[r], sc, bias_m[r]));
      exp_row_q.push_back(row_t'(r));
    end
  endtask

  task automatic expect_results(input int n, input bit rand_ready);
    int got;
    got = 0;
    while (got < n) begin
      @(posedge clk);
      out_ready <= rand_ready ? ($urandom_range(1, 0) == 1) : 1'b1;
      @(negedge clk);
      if (out_valid && out_ready) begin
        if (exp_res_q.size() == 0) fail_run("a result came out that was never expected");
        check_res("out_data", out_data, exp_res_q.pop_front());
        check_row("out_row", out_row, exp_row_q.pop_front());
        got++;
      end
    end
  endtask

  task automatic expect_quiet(input int n);
    budget += n;
    repeat (n) begin
      @(negedge clk);
      if (out_valid) fail_run("an extra result came out after the drain");
    end
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////
  task automatic register_access();
    axi_data_t d;
    axi_resp_t rs;
    if (out_valid || bvalid || rvalid) fail_run("a valid output was high after reset");
    read_check(ADDR_MODE, 32'd0);
    read_check(ADDR_LEN, 32'd9);
    read_check(ADDR_POF, ROWS);
    for (int r = 0; r < ROWS; r++) begin
      read_check(ADDR_SCALE + 4 * r, 32'd256);
      read_check(ADDR_BIAS + 4 * r, 32'd0);
    end
    write_cfg(ADDR_MODE, 32'd1);
    read_check(ADDR_MODE, 32'd1);
    write_cfg(ADDR_LEN, 32'd12);
    read_check(ADDR_LEN, 32'd12);
    write_cfg(ADDR_POF, 32'd3);
    read_check(ADDR_POF, 32'd3);
    // pof saturates at both ends
    write_cfg(ADDR_POF, 32'd0);
    read_check(ADDR_POF, 32'd1);
    write_cfg(ADDR_POF, 32'd7);
    read_check(ADDR_POF, ROWS);
    for (int r = 0; r < ROWS; r++) begin
      write_cfg(ADDR_SCALE + 4 * r, 300 + 17 * r);
      read_check(ADDR_SCALE + 4 * r, 300 + 17 * r);
      write_cfg(ADDR_BIAS + 4 * r, 10 + r);
      read_check(ADDR_BIAS + 4 * r, 10 + r);
    end
    // holes in the map
    axi_write(8'h0c, 32'h55, rs);
    check_resp("bresp", rs, RESP_SLVERR);
    axi_read(8'h0c, d, rs);
    check_resp("rresp", rs, RESP_SLVERR);
    check_data("rdata", d, 32'd0);
    axi_read(8'h12, d, rs);
    check_resp("rresp", rs, RESP_SLVERR);
    check_data("rdata", d, 32'd0);
    axi_write(8'h30, 32'h1234, rs);
    check_resp("bresp", rs, RESP_SLVERR);
  endtask

  task automatic shared_scale_tile();
    write_cfg(ADDR_MODE, MODE_SHARED);
    write_cfg(ADDR_LEN, 32'd9);
    write_cfg(ADDR_POF, ROWS);
    write_cfg(ADDR_SCALE, 32'd200);
    for (int r = 0; r < ROWS; r++) begin
      // other scales must be ignored
      if (r > 0) write_cfg(ADDR_SCALE + 4 * r, 32'd900);
      write_cfg(ADDR_BIAS + 4 * r, 3 * r);
    end
    send_tile(1'b1, '0, '0);
    expect_results(ROWS, 1'b0);
  endtask

  task automatic per_row_clamp();
    act_t [ROWS-1:0] ac;
    wgt_t [ROWS-1:0] wc;
    write_cfg(ADDR_MODE, MODE_PER_ROW);
    write_cfg(ADDR_SCALE + 0, 32'd256);
    write_cfg(ADDR_SCALE + 4, 32'd512);
    write_cfg(ADDR_SCALE + 8, 32'd128);
    write_cfg(ADDR_SCALE + 12, 32'd1024);
    write_cfg(ADDR_BIAS + 0, axi_data_t'(-100));
    for (int r = 1; r < ROWS; r++) write_cfg(ADDR_BIAS + 4 * r, 32'd0);
    // row 0 negative after bias, row 1 over 127, row 3 negative sum
    ac[0] = 5;
    ac[1] = 10;
    ac[2] = 8;
    ac[3] = -2;
    wc[0] = 1;
    wc[1] = 2;
    wc[2] = 3;
    wc[3] = 3;
    send_tile(1'b0, ac, wc);
    expect_results(ROWS, 1'b0);
  endtask

  task automatic partial_drain();
    act_t [ROWS-1:0] ac;
    wgt_t [ROWS-1:0] wc;
    write_cfg(ADDR_MODE, MODE_SHARED);
    write_cfg(ADDR_SCALE, 32'd256);
    write_cfg(ADDR_BIAS + 0, 32'd0);
    write_cfg(ADDR_POF, 32'd2);
    for (int r = 0; r < ROWS; r++) begin
      ac[r] = act_t'(r + 1);
      wc[r] = 2;
    end
    send_tile(1'b0, ac, wc);
    expect_results(2, 1'b0);
    expect_quiet(12);
    // rows 2 and 3 held sums that were never drained
    write_cfg(ADDR_POF, ROWS);
    for (int r = 0; r < ROWS; r++) begin
      ac[r] = act_t'(ROWS - r);
      wc[r] = 1;
    end
    send_tile(1'b0, ac, wc);
    expect_results(ROWS, 1'b0);
  endtask

  task automatic back_pressure();
    @(posedge clk);
    out_ready <= 1'b0;
    send_tile(1'b1, '0, '0);
    send_tile(1'b1, '0, '0);
    // fifo now holds two tiles so no third may start
    repeat (16) begin
      @(negedge clk);
      if (px_ready) fail_run("px_ready stayed high while the output fifo was full");
      if (!out_valid) fail_run("out_valid dropped while results were held back");
    end
    expect_results(2 * ROWS, 1'b0);
  endtask

  task automatic random_tiles();
    int len;
    for (int t = 0; t < 10; t++) begin
      len = $urandom_range(16, 1);
      write_cfg(ADDR_MODE, $urandom_range(1, 0));
      write_cfg(ADDR_LEN, len);
      write_cfg(ADDR_POF, $urandom_range(ROWS, 1));
      for (int r = 0; r < ROWS; r++) begin
        write_cfg(ADDR_SCALE + 4 * r, $urandom_range(512, 16));
        write_cfg(ADDR_BIAS + 4 * r, axi_data_t'(int'($urandom_range(128, 0)) - 64));
      end
      send_tile(1'b1, '0, '0);
      expect_results(pof_m, 1'b1);
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial begin
    void'($urandom(85732));
    reset = 1'b1;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    bready = 1'b0;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b0;
    px_valid = 1'b0;
    px_act = '0;
    px_wgt = '0;
    out_ready = 1'b0;
    // reset values of the register file
    mode_m = MODE_SHARED;
    len_m = 16'd9;
    pof_m = pof_t'(ROWS);
    for (int r = 0; r < ROWS; r++) begin
      scale_m[r] = 16'd256;
      bias_m[r] = '0;
    end
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    register_access();
    shared_scale_tile();
    per_row_clamp();
    partial_drain();
    back_pressure();
    random_tiles();
    expect_quiet(10);
    $display(">>> PASS");
    $finish;
  end

endmodule
